// File: list.f
logic/sdram_pkg.sv
logic/refresh_timer.sv
logic/bank_timing.sv
logic/command_scheduler.sv
logic/sdram_ctrl_top.sv
verification/sdram_checker.sv
verification/sdram_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module sdram_ctrl_tb -f list.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
else
  exit 1
fi

// File: verification/sdram_ctrl_tb.sv
`timescale 1ns/1ps

module sdram_ctrl_tb import sdram_pkg::*;;

  localparam int REFRESH_INTERVAL = 400;
  localparam int NUM_REQ          = 40;
  localparam int WAIT_LIMIT       = 1000;

  logic        CLK = 1'b0;
  logic        RST;
  word_addr_t  rand_addr;
  logic        rand_we;
  logic        rand_req;
  logic        rand_grant;
  word_addr_t  bulk_addr;
  logic        bulk_we;
  logic        bulk_req;
  logic        bulk_grant;
  sdram_cmd_t  sdram_cmd;
  bank_t       sdram_bank;
  sdram_addr_t sdram_addr;
  int          chk_errors;
  int          refreshes;
  int          tb_errors = 0;
  int          timeouts = 0;
  int          err_before;
  int          ref_before;

  always #50 CLK = ~CLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // few rows and two banks, so pages get hit and missed
  function automatic word_addr_t pick_addr(input logic [31:0] r);
    return {10'd0, r[17:16], 1'b0, r[20], r[11:0]};
  endfunction

  task automatic run_port(input bit is_bulk, input logic [31:0] seed, input int idle_min);
    logic [31:0] s;
    int          waited;
    logic        got;
    s = seed;
    for (int n = 0; n < NUM_REQ; n++)
    begin
      s = lcg_next(s);
      @(posedge CLK);
      #1;
      if (is_bulk)
      begin
        bulk_addr = pick_addr(s);
        bulk_we   = s[31];
        bulk_req  = 1'b1;
      end
      else
      begin
        rand_addr = pick_addr(s);
        rand_we   = s[31];
        rand_req  = 1'b1;
      end
      waited = 0;
      got    = 1'b0;
      while (!got && waited < WAIT_LIMIT)
      begin
        @(posedge CLK);
        #1;
        got = is_bulk ? bulk_grant : rand_grant;
        waited++;
      end
      if (is_bulk)
        bulk_req = 1'b0;
      else
        rand_req = 1'b0;
      if (!got)
      begin
        $display("%s port got no grant within %0d cycles", is_bulk ? "bulk" : "rand",
                 WAIT_LIMIT);
        timeouts++;
        return;
      end
      repeat (idle_min + int'(s[26:24])) @(posedge CLK);
    end
  endtask

  sdram_ctrl_top #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) u_dut (.*);

  sdram_checker #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) u_checker (
    .errors    (chk_errors),
    .refreshes (refreshes),
    .*
  );

  initial
  begin
    RST = 1'b0;
    rand_addr = '0;
    rand_we   = 1'b0;
    rand_req  = 1'b0;
    bulk_addr = '0;
    bulk_we   = 1'b0;
    bulk_req  = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b1;
    repeat (3) @(posedge CLK);
    #1;
    $display("test reset finished, errors %0d", chk_errors);

    err_before = chk_errors + timeouts;
    fork
      run_port(1'b1, 32'h53d4c03b, 8);
      run_port(1'b0, 32'h53d4c03b ^ 32'h9e3779b9, 1);
    join
    #1;
    $display("test traffic finished, errors %0d", chk_errors + timeouts - err_before);

    // idle bus, refresh must still come
    err_before = chk_errors;
    ref_before = refreshes;
    repeat (REFRESH_INTERVAL + 40) @(posedge CLK);
    #1;
    if (refreshes == ref_before)
    begin
      $display("no refresh seen on an idle bus");
      tb_errors++;
    end
    $display("test refresh finished, errors %0d", chk_errors - err_before + tb_errors);

    $display("tests 3, refreshes %0d, errors %0d, timeouts %0d", refreshes,
             chk_errors + tb_errors, timeouts);
    if (chk_errors + tb_errors + timeouts == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: verification/sdram_checker.sv
`timescale 1ns/1ps

module sdram_checker import sdram_pkg::*; #(
  parameter int T_RCD            = 3,
  parameter int T_RP             = 3,
  parameter int T_RFC            = 9,
  parameter int T_RW             = 2,
  parameter int T_WR             = 2,
  parameter int REFRESH_INTERVAL = 400,
  parameter int REFRESH_MARGIN   = 32
) (
  input  logic        CLK,
  input  logic        RST,
  input  word_addr_t  rand_addr,
  input  logic        rand_we,
  input  logic        rand_req,
  input  logic        rand_grant,
  input  word_addr_t  bulk_addr,
  input  logic        bulk_we,
  input  logic        bulk_req,
  input  logic        bulk_grant,
  input  sdram_cmd_t  sdram_cmd,
  input  bank_t       sdram_bank,
  input  sdram_addr_t sdram_addr,
  output int          errors,
  output int          refreshes
);

  int         cyc = 0;
  int         rst_cyc = 0;
  int         last_cyc = -100;
  int         last_wr_cyc = -100;
  int         since_arsr = 0;
  sdram_cmd_t last_cmd = NOP;
  logic       page_open = 1'b0;
  logic [13:0] open_page = '0;
  logic       p_req = 1'b0;    // inputs of the cycle before
  logic       p_bulk = 1'b0;
  logic       p_we = 1'b0;
  word_addr_t p_addr = '0;
  logic [14:0] exp_ba;

  initial
  begin
    errors    = 0;
    refreshes = 0;
  end

  // minimum distance from prev to cur
  function automatic int req_gap(sdram_cmd_t prev, sdram_cmd_t cur);
    int g;
    case (prev)
      ACTV:        g = T_RCD;
      PRCH:        g = T_RP;
      ARSR:        g = T_RFC;
      READ, WRITE: g = T_RW;
      default:     g = 0;
    endcase
    if (prev == WRITE && cur == PRCH)
      g = g + T_WR;
    return g;
  endfunction

  // {bank, address bus} for ACTV and READ/WRITE
  function automatic logic [14:0] expect_bank_addr(sdram_cmd_t cmd, word_addr_t a);
    if (cmd == ACTV)
      return {a[13:12], 1'b0, a[25:14]};
    return {a[13:12], a[11:10], 1'b0, a[9:0]};  // A10 stays low
  endfunction

  task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
    $display("** Error: %s is %h, expected %h (cycle %0d)", name, got, exp, cyc);
    errors++;
  endtask

  task automatic plain_error(string what);
    $display("Error at cycle %0d: %s", cyc, what);
    errors++;
  endtask

  always @(posedge CLK)
  begin
    cyc++;
    if (!RST)
    begin
      rst_cyc++;
      if (rst_cyc > 1 && (sdram_cmd !== NOP || rand_grant !== 1'b0 || bulk_grant !== 1'b0))
        plain_error("command or grant active during reset");
      page_open  = 1'b0;
      last_cmd   = NOP;
      last_cyc   = -100;
      since_arsr = -1;  // timer restarts here just as at an ARSR
    end
    else
    begin
      since_arsr++;
      if (sdram_cmd !== NOP)
      begin
        if (cyc - last_cyc < req_gap(last_cmd, sdram_cmd))
          plain_error("command issued before the previous gap elapsed");
        if (sdram_cmd == PRCH && cyc - last_wr_cyc < T_RW + T_WR)
          plain_error("precharge violates write recovery");
        last_cmd = sdram_cmd;
        last_cyc = cyc;
      end
      if (sdram_cmd != READ && sdram_cmd != WRITE && (rand_grant !== 1'b0 || bulk_grant !== 1'b0))
        plain_error("grant without a read or write");
      exp_ba = expect_bank_addr(sdram_cmd, p_addr);
      case (sdram_cmd)
        ACTV:
        begin
          if (page_open || !p_req)
            plain_error("activate while a page is open or nothing requested");
          if (sdram_bank !== exp_ba[14:13])
            value_error("sdram_bank", 32'(sdram_bank), 32'(exp_ba[14:13]));
          if (sdram_addr !== exp_ba[12:0])
            value_error("sdram_addr", 32'(sdram_addr), 32'(exp_ba[12:0]));
          page_open = 1'b1;
          open_page = p_addr[25:12];
        end
        PRCH:
        begin
          if (!page_open)
            plain_error("precharge with no page open");
          if (sdram_addr !== 13'h0400)
            value_error("sdram_addr", 32'(sdram_addr), 32'h0400);
          page_open = 1'b0;
        end
        ARSR:
        begin
          if (page_open)
            plain_error("refresh while a page is open");
          if (since_arsr < REFRESH_INTERVAL)
            plain_error("refresh before the interval elapsed");
          since_arsr = 0;
          refreshes++;
        end
        READ, WRITE:
        begin
          if (!p_req || !page_open || p_addr[25:12] != open_page)
            plain_error("read or write outside the open page");
          if (since_arsr >= REFRESH_INTERVAL + 2)
            plain_error("read or write served while refresh is due");
          if (sdram_cmd !== (p_we ? WRITE : READ))
            value_error("sdram_cmd", 32'(sdram_cmd), 32'(p_we ? WRITE : READ));
          if (sdram_bank !== exp_ba[14:13])
            value_error("sdram_bank", 32'(sdram_bank), 32'(exp_ba[14:13]));
          if (sdram_addr !== exp_ba[12:0])
            value_error("sdram_addr", 32'(sdram_addr), 32'(exp_ba[12:0]));
          if (bulk_grant !== p_bulk)
            value_error("bulk_grant", 32'(bulk_grant), 32'(p_bulk));
          if (rand_grant !== !p_bulk)
            value_error("rand_grant", 32'(rand_grant), 32'(!p_bulk));
          if (sdram_cmd == WRITE)
            last_wr_cyc = cyc;
        end
        default: ;
      endcase
      if (since_arsr == REFRESH_INTERVAL + REFRESH_MARGIN + 1)
        plain_error("no refresh within the refresh interval");
    end
    p_req  = bulk_req | rand_req;
    p_bulk = bulk_req;  // bulk wins
    p_we   = bulk_req ? bulk_we : rand_we;
    p_addr = bulk_req ? bulk_addr : rand_addr;
  end

endmodule

// File: logic/sdram_ctrl_top.sv
`timescale 1ns/1ps

module sdram_ctrl_top import sdram_pkg::*; #(
  parameter int T_RCD            = 3,
  parameter int T_RP             = 3,
  parameter int T_RFC            = 9,
  parameter int T_RW             = 2,
  parameter int T_WR             = 2,
  parameter int REFRESH_INTERVAL = 400
) (
  input  logic        CLK,
  input  logic        RST,

  input  word_addr_t  rand_addr,
  input  logic        rand_we,
  input  logic        rand_req,
  output logic        rand_grant,

  input  word_addr_t  bulk_addr,
  input  logic        bulk_we,
  input  logic        bulk_req,
  output logic        bulk_grant,

  output sdram_cmd_t  sdram_cmd,
  output bank_t       sdram_bank,
  output sdram_addr_t sdram_addr
);

  logic       refresh_due;
  logic       refresh_ack;
  logic       cmd_ready;
  logic       prch_ready;
  logic       issue;
  sdram_cmd_t issued_cmd;

  refresh_timer #(
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) u_refresh_timer (
    .CLK         (CLK),
    .RST         (RST),
    .refresh_ack (refresh_ack),
    .refresh_due (refresh_due)
  );

  bank_timing #(
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RFC (T_RFC),
    .T_RW  (T_RW),
    .T_WR  (T_WR)
  ) u_bank_timing (
    .CLK        (CLK),
    .RST        (RST),
    .issue      (issue),
    .issued_cmd (issued_cmd),
    .cmd_ready  (cmd_ready),
    .prch_ready (prch_ready)
  );

  command_scheduler u_command_scheduler (
    .CLK         (CLK),
    .RST         (RST),
    .rand_addr   (rand_addr),
    .rand_we     (rand_we),
    .rand_req    (rand_req),
    .rand_grant  (rand_grant),
    .bulk_addr   (bulk_addr),
    .bulk_we     (bulk_we),
    .bulk_req    (bulk_req),
    .bulk_grant  (bulk_grant),
    .refresh_due (refresh_due),
    .refresh_ack (refresh_ack),
    .cmd_ready   (cmd_ready),
    .prch_ready  (prch_ready),
    .issue       (issue),
    .issued_cmd  (issued_cmd),
    .sdram_cmd   (sdram_cmd),
    .sdram_bank  (sdram_bank),
    .sdram_addr  (sdram_addr)
  );

endmodule

// File: logic/command_scheduler.sv
`timescale 1ns/1ps

module command_scheduler import sdram_pkg::*; (
  input  logic        CLK,
  input  logic        RST,

  input  word_addr_t  rand_addr,
  input  logic        rand_we,
  input  logic        rand_req,
  output logic        rand_grant,

  input  word_addr_t  bulk_addr,
  input  logic        bulk_we,
  input  logic        bulk_req,
  output logic        bulk_grant,

  input  logic        refresh_due,
  output logic        refresh_ack,

  input  logic        cmd_ready,
  input  logic        prch_ready,
  output logic        issue,
  output sdram_cmd_t  issued_cmd,

  output sdram_cmd_t  sdram_cmd,
  output bank_t       sdram_bank,
  output sdram_addr_t sdram_addr
);

  logic        req_any;
  word_addr_t  sel_addr;
  logic        sel_we;
  page_t       sel_page;
  logic        page_hit;
  logic        is_rw;

  logic        page_open;
  page_t       open_page;

  sdram_cmd_t  next_cmd;
  bank_t       next_bank;
  sdram_addr_t next_addr;

  // bulk port always wins
  assign req_any  = bulk_req | rand_req;
  assign sel_addr = bulk_req ? bulk_addr : rand_addr;
  assign sel_we   = bulk_req ? bulk_we : rand_we;
  assign sel_page = addr_page(sel_addr);
  assign page_hit = page_open && (sel_page == open_page);

  // command choice, refresh first
  always_comb
  begin
    next_cmd = NOP;
    if (refresh_due)
    begin
      if (page_open)
      begin
        if (prch_ready)
          next_cmd = PRCH;  // close page before refresh
      end
      else
      begin
        next_cmd = ARSR;
      end
    end
    else if (req_any)
    begin
      if (page_hit)
        next_cmd = sel_we ? WRITE : READ;
      else if (page_open)
      begin
        if (prch_ready)
          next_cmd = PRCH;  // miss, other page open
      end
      else
      begin
        next_cmd = ACTV;
      end
    end
  end

  assign is_rw = (next_cmd == READ) || (next_cmd == WRITE);

  always_comb
  begin
    next_bank = addr_bank(sel_addr);
    next_addr = PRCH_ALL_ADDR;
    case (next_cmd)
      ACTV:
        next_addr = row_to_addr(addr_row(sel_addr));
      READ, WRITE:
        next_addr = col_to_addr(addr_col(sel_addr));
      default:
      begin
        next_bank = open_page[1:0];  // precharge all, bank unused
        next_addr = PRCH_ALL_ADDR;
      end
    endcase
  end

  assign issue       = cmd_ready && (next_cmd != NOP);
  assign issued_cmd  = next_cmd;
  assign refresh_ack = issue && (next_cmd == ARSR);

  // command, grants and page state
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      sdram_cmd  <= NOP;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
      page_open  <= 1'b0;
    end
    else
    begin
      sdram_cmd  <= issue ? next_cmd : NOP;
      bulk_grant <= issue && is_rw && bulk_req;
      rand_grant <= issue && is_rw && !bulk_req;

      if (issue && next_cmd == ACTV)
        page_open <= 1'b1;
      else if (issue && next_cmd == PRCH)
        page_open <= 1'b0;
    end
  end

  // payload, only meaningful with a command
  always_ff @(posedge CLK)
  begin
    if (issue)
    begin
      sdram_bank <= next_bank;
      sdram_addr <= next_addr;
      if (next_cmd == ACTV)
        open_page <= sel_page;
    end
  end

endmodule

// File: logic/bank_timing.sv
`timescale 1ns/1ps

module bank_timing import sdram_pkg::*; #(
  parameter int T_RCD = 3,
  parameter int T_RP  = 3,
  parameter int T_RFC = 9,
  parameter int T_RW  = 2,
  parameter int T_WR  = 2
) (
  input  logic       CLK,
  input  logic       RST,
  input  logic       issue,
  input  sdram_cmd_t issued_cmd,
  output logic       cmd_ready,
  output logic       prch_ready
);

  // wide enough for any single gap
  localparam int CNT_W = $clog2(T_RCD + T_RP + T_RFC + T_RW + T_WR + 1);

  logic [CNT_W-1:0] gap;
  logic [CNT_W-1:0] gap_cnt;  // general command spacing
  logic [CNT_W-1:0] wr_cnt;   // write recovery before PRCH

  always_comb
  begin
    case (issued_cmd)
      ACTV:        gap = CNT_W'(T_RCD);
      PRCH:        gap = CNT_W'(T_RP);
      ARSR:        gap = CNT_W'(T_RFC);
      READ, WRITE: gap = CNT_W'(T_RW);
      default:     gap = '0;
    endcase
  end

  // counters load at the edge where the command is registered,
  // so zero is reached gap cycles after it shows on the bus
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      gap_cnt <= '0;
      wr_cnt  <= '0;
    end
    else
    begin
      if (issue)
        gap_cnt <= gap;
      else if (gap_cnt != '0)
        gap_cnt <= gap_cnt - 1'b1;

      if (issue && issued_cmd == WRITE)
        wr_cnt <= CNT_W'(T_RW + T_WR);
      else if (wr_cnt != '0)
        wr_cnt <= wr_cnt - 1'b1;
    end
  end

  assign cmd_ready  = (gap_cnt == '0);
  assign prch_ready = (wr_cnt == '0);  // no write recovery pending

endmodule

// File: logic/refresh_timer.sv
`timescale 1ns/1ps

module refresh_timer #(
  parameter int REFRESH_INTERVAL = 400
) (
  input  logic CLK,
  input  logic RST,
  input  logic refresh_ack,
  output logic refresh_due
);

  localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

  logic [CNT_W-1:0] count;

  // count saturates at the interval and waits there for the ack
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      count       <= '0;
      refresh_due <= 1'b0;
    end
    else if (refresh_ack)
    begin
      count       <= '0;  // new interval starts with the ARSR
      refresh_due <= 1'b0;
    end
    else if (count == CNT_W'(REFRESH_INTERVAL))
    begin
      refresh_due <= 1'b1;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: logic/sdram_pkg.sv
package sdram_pkg;

  // SDRAM command encoding as {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOP   = 3'b111,
    ACTV  = 3'b011,  // open a row
    READ  = 3'b101,
    WRITE = 3'b100,
    PRCH  = 3'b010,  // close a row
    ARSR  = 3'b001   // auto refresh
  } sdram_cmd_t;

  typedef logic [25:0] word_addr_t;
  typedef logic [11:0] row_t;
  typedef logic [1:0]  bank_t;
  typedef logic [11:0] col_t;
  typedef logic [13:0] page_t;       // {row, bank}
  typedef logic [12:0] sdram_addr_t;

  // request address fields
  localparam int ROW_MSB  = 25;
  localparam int ROW_LSB  = 14;
  localparam int BANK_MSB = 13;
  localparam int BANK_LSB = 12;
  localparam int COL_MSB  = 11;
  localparam int COL_LSB  = 0;

  localparam sdram_addr_t PRCH_ALL_ADDR = 13'h0400;  // A10 high, all banks

  function automatic page_t addr_page(word_addr_t addr);
    return addr[ROW_MSB:BANK_LSB];
  endfunction

  function automatic row_t addr_row(word_addr_t addr);
    return addr[ROW_MSB:ROW_LSB];
  endfunction

  function automatic bank_t addr_bank(word_addr_t addr);
    return addr[BANK_MSB:BANK_LSB];
  endfunction

  function automatic col_t addr_col(word_addr_t addr);
    return addr[COL_MSB:COL_LSB];
  endfunction

  // row drives the bus as is during ACTV
  function automatic sdram_addr_t row_to_addr(row_t row);
    return {1'b0, row};
  endfunction

  // column skips A10, which would request auto precharge
  function automatic sdram_addr_t col_to_addr(col_t col);
    return {col[11:10], 1'b0, col[9:0]};
  endfunction

endpackage
